// ==== bldc_params.svh ====
`ifndef BLDC_PARAMS_SVH
`define BLDC_PARAMS_SVH

// Register map
`define BLDC_ADDR_CTRL      8'h00
`define BLDC_ADDR_DUTY      8'h04
`define BLDC_ADDR_PERIOD    8'h08
`define BLDC_ADDR_STATUS    8'h0C

// Field widths
`define BLDC_DUTY_W         8
`define BLDC_PERIOD_W       24

// Gate turn-on delay in clk cycles
`define BLDC_DEAD_CYCLES    4

// Reset values
`define BLDC_RST_DUTY       8'h10
`define BLDC_RST_PERIOD     24'd1000

`endif

// ==== bldcPkg.sv ====
`default_nettype none

package bldcPkg;

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    // One-hot over phases, bit 0 = a, bit 1 = b, bit 2 = c
    typedef struct packed {
        logic [2:0] highSel;
        logic [2:0] lowSel;
    } phasePattern_t;

    typedef struct packed {
        logic aHi;
        logic aLo;
        logic bHi;
        logic bLo;
        logic cHi;
        logic cLo;
    } gates_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ALIGN = 2'd1,
        RUN   = 2'd2
    } fsmState_t;

    typedef struct packed {
        fsmState_t  state;
        logic [2:0] step;   // 0 to 5
    } status_t;

endpackage

`default_nettype wire

// ==== bldcRegs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module bldcRegs (
    input  wire                      clk,
    input  wire                      nRst,
    input  wire bldcPkg::apbReq_t    apbReq,
    output bldcPkg::apbRsp_t         apbRsp,
    input  wire bldcPkg::status_t    status,
    output logic                     enable,
    output logic                     reverse,
    output logic [`BLDC_DUTY_W-1:0]   duty,
    output logic [`BLDC_PERIOD_W-1:0] period
);

    logic        access;
    logic        isCtrl;
    logic        isDuty;
    logic        isPeriod;
    logic        isStatus;
    logic        badAddr;
    logic        accErr;
    logic        wrEn;
    logic [31:0] rdData;

    assign access   = apbReq.psel & apbReq.penable;
    assign isCtrl   = (apbReq.paddr == `BLDC_ADDR_CTRL);
    assign isDuty   = (apbReq.paddr == `BLDC_ADDR_DUTY);
    assign isPeriod = (apbReq.paddr == `BLDC_ADDR_PERIOD);
    assign isStatus = (apbReq.paddr == `BLDC_ADDR_STATUS);
    assign badAddr  = ~(isCtrl | isDuty | isPeriod | isStatus);

    // STATUS is read-only
    assign accErr = badAddr | (apbReq.pwrite & isStatus);
    assign wrEn   = access & apbReq.pwrite & ~accErr;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            enable  <= 1'b0;
            reverse <= 1'b0;
            duty    <= `BLDC_RST_DUTY;
            period  <= `BLDC_RST_PERIOD;
        end
        else if (wrEn) begin
            if (isCtrl) begin
                enable  <= apbReq.pwdata[0];
                reverse <= apbReq.pwdata[1];
            end
            if (isDuty) begin
                duty <= apbReq.pwdata[`BLDC_DUTY_W-1:0];
            end
            if (isPeriod) begin
                period <= apbReq.pwdata[`BLDC_PERIOD_W-1:0];
            end
        end
    end

    always_comb begin
        case (apbReq.paddr)
            `BLDC_ADDR_CTRL: begin
                rdData = {30'd0, reverse, enable};
            end
            `BLDC_ADDR_DUTY: begin
                rdData = {{(32-`BLDC_DUTY_W){1'b0}}, duty};
            end
            `BLDC_ADDR_PERIOD: begin
                rdData = {{(32-`BLDC_PERIOD_W){1'b0}}, period};
            end
            `BLDC_ADDR_STATUS: begin
                rdData = {27'd0, status};   // {state, step}
            end
            default: begin
                rdData = 32'd0;
            end
        endcase
    end

    // No wait states
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.prdata  = apbReq.psel ? rdData : 32'd0;
    assign apbRsp.pslverr = access & accErr;

endmodule

`default_nettype wire

// ==== stepTimer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module stepTimer (
    input  wire                       clk,
    input  wire                       nRst,
    input  wire                       enable,
    input  wire [`BLDC_PERIOD_W-1:0]  period,
    output logic                      stepLast
);

    logic [`BLDC_PERIOD_W-1:0] count;
    logic                      countZero;

    assign countZero = (count == '0);

    // Counts period down to 0, so one step spans period+1 cycles
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            count <= `BLDC_RST_PERIOD;
        end
        else if (!enable || countZero) begin
            count <= period;    // New period only takes effect here
        end
        else begin
            count <= count - 1'b1;
        end
    end

    assign stepLast = enable & countZero;

endmodule

`default_nettype wire

// ==== commutationFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module commutationFsm (
    input  wire                         clk,
    input  wire                         nRst,
    input  wire                         enable,
    input  wire                         reverse,
    input  wire                         stepLast,
    output bldcPkg::phasePattern_t      pattern,
    output bldcPkg::status_t            status
);

    import bldcPkg::*;

    localparam logic [2:0] phA = 3'b001;
    localparam logic [2:0] phB = 3'b010;
    localparam logic [2:0] phC = 3'b100;

    fsmState_t  state;
    logic [2:0] step;
    logic [2:0] nextStep;

    always_comb begin
        if (reverse) begin
            nextStep = (step == 3'd0) ? 3'd5 : step - 3'd1;
        end
        else begin
            nextStep = (step == 3'd5) ? 3'd0 : step + 3'd1;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state <= IDLE;
            step  <= 3'd0;
        end
        else if (!enable) begin
            state <= IDLE;
            step  <= 3'd0;
        end
        else begin
            case (state)
                IDLE: state <= ALIGN;   // Align holds step 0 for one step
                ALIGN, RUN: begin
                    if (stepLast) begin
                        state <= RUN;
                        step  <= nextStep;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        pattern = '0;
        if (state != IDLE) begin
            case (step)
                3'd0: pattern = '{highSel: phA, lowSel: phB};
                3'd1: pattern = '{highSel: phA, lowSel: phC};
                3'd2: pattern = '{highSel: phB, lowSel: phC};
                3'd3: pattern = '{highSel: phB, lowSel: phA};
                3'd4: pattern = '{highSel: phC, lowSel: phA};
                3'd5: pattern = '{highSel: phC, lowSel: phB};
                default: pattern = '0;
            endcase
        end
    end

    assign status = '{state: state, step: step};

endmodule

`default_nettype wire

// ==== pwmGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module pwmGenerator (
    input  wire                          clk,
    input  wire                          nRst,
    input  wire [`BLDC_DUTY_W-1:0]       duty,
    input  wire                          stepLast,
    input  wire bldcPkg::phasePattern_t  pattern,
    output logic                         pwm
);

    logic [`BLDC_DUTY_W-1:0] dutyQ;   // Duty for the current step
    logic [`BLDC_DUTY_W-1:0] cnt;
    logic                    allOff;
    logic                    dutyFull;
    logic                    dutyZero;

    assign allOff   = (pattern == '0);
    assign dutyFull = (dutyQ == '1);
    assign dutyZero = (dutyQ == '0);

    // On time is duty cycles, off time is ~duty+1, so one period is 256 cycles
    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            dutyQ <= `BLDC_RST_DUTY;
            cnt   <= '0;
            pwm   <= 1'b0;
        end
        else if (allOff) begin
            // Phases off, park low and start high on the next cycle
            dutyQ <= duty;
            cnt   <= '0;
            pwm   <= 1'b0;
        end
        else if (stepLast) begin
            dutyQ <= duty;
            cnt   <= duty - 1'b1;
            pwm   <= (duty != '0);
        end
        else if (dutyFull) begin
            pwm <= 1'b1;
        end
        else if (dutyZero) begin
            pwm <= 1'b0;
        end
        else if (cnt == '0) begin
            pwm <= ~pwm;
            cnt <= pwm ? ~dutyQ : dutyQ - 1'b1;   // Load off or on time
        end
        else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== deadTimeInserter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module deadTimeInserter (
    input  wire                          clk,
    input  wire                          nRst,
    input  wire bldcPkg::phasePattern_t  pattern,
    input  wire                          pwm,
    output bldcPkg::gates_t              gates
);

    import bldcPkg::*;

    localparam int CntW = $clog2(`BLDC_DEAD_CYCLES + 1);

    gates_t                 req;
    logic [5:0]             reqVec;
    logic [5:0]             gateQ;
    logic [5:0][CntW-1:0]   onCnt;

    // High side chops, low side of the same leg rectifies
    assign req.aHi = pattern.highSel[0] & pwm;
    assign req.aLo = (pattern.highSel[0] & ~pwm) | pattern.lowSel[0];
    assign req.bHi = pattern.highSel[1] & pwm;
    assign req.bLo = (pattern.highSel[1] & ~pwm) | pattern.lowSel[1];
    assign req.cHi = pattern.highSel[2] & pwm;
    assign req.cLo = (pattern.highSel[2] & ~pwm) | pattern.lowSel[2];

    assign reqVec = req;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            gateQ <= '0;
            onCnt <= '0;
        end
        else begin
            for (int k = 0; k < 6; k++) begin
                if (!reqVec[k]) begin
                    onCnt[k] <= '0;   // Off at once
                    gateQ[k] <= 1'b0;
                end
                else if (onCnt[k] == CntW'(`BLDC_DEAD_CYCLES)) begin
                    gateQ[k] <= 1'b1;
                end
                else begin
                    onCnt[k] <= onCnt[k] + 1'b1;
                end
            end
        end
    end

    assign gates = gates_t'(gateQ);

endmodule

`default_nettype wire

// ==== bldcTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module bldcTop (
    input  wire                       clk,
    input  wire                       nRst,
    input  wire bldcPkg::apbReq_t     apbReq,
    output bldcPkg::apbRsp_t          apbRsp,
    output bldcPkg::gates_t           gates,
    output bldcPkg::status_t          status
);

    import bldcPkg::*;

    logic                      enable;
    logic                      reverse;
    logic [`BLDC_DUTY_W-1:0]   duty;
    logic [`BLDC_PERIOD_W-1:0] period;
    logic                      stepLast;
    logic                      pwm;
    phasePattern_t             pattern;

    bldcRegs uRegs (
        .clk     (clk),
        .nRst    (nRst),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .status  (status),
        .enable  (enable),
        .reverse (reverse),
        .duty    (duty),
        .period  (period)
    );

    stepTimer uTimer (
        .clk      (clk),
        .nRst     (nRst),
        .enable   (enable),
        .period   (period),
        .stepLast (stepLast)
    );

    commutationFsm uFsm (
        .clk      (clk),
        .nRst     (nRst),
        .enable   (enable),
        .reverse  (reverse),
        .stepLast (stepLast),
        .pattern  (pattern),
        .status   (status)
    );

    pwmGenerator uPwm (
        .clk      (clk),
        .nRst     (nRst),
        .duty     (duty),
        .stepLast (stepLast),
        .pattern  (pattern),
        .pwm      (pwm)
    );

    deadTimeInserter uDeadTime (
        .clk     (clk),
        .nRst    (nRst),
        .pattern (pattern),
        .pwm     (pwm),
        .gates   (gates)
    );

endmodule

`default_nettype wire

// ==== tbClkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClkGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

endmodule

`default_nettype wire

// ==== bldcChk.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module bldcChk (
    input wire                         clk,
    input wire                         nRst,
    input wire bldcPkg::gates_t        gates,
    input wire bldcPkg::phasePattern_t pattern,
    input wire bldcPkg::apbReq_t       apbReq,
    input wire bldcPkg::apbRsp_t       apbRsp
);

    import bldcPkg::*;

    int unsigned failCount = 0;   // Read by the testbench at the end
    logic        mapped;          // Access the register map accepts

    assign mapped = (apbReq.paddr inside {`BLDC_ADDR_CTRL, `BLDC_ADDR_DUTY,
                                          `BLDC_ADDR_PERIOD}) ||
                    (apbReq.paddr == `BLDC_ADDR_STATUS && !apbReq.pwrite);

    aNoShootThrough: assert property (@(posedge clk) disable iff (!nRst)
        !((gates.aHi & gates.aLo) | (gates.bHi & gates.bLo) | (gates.cHi & gates.cLo)))
        else begin
            failCount++;
            $error("Both gates of one leg are on");
        end

    aPatternOneHot: assert property (@(posedge clk) disable iff (!nRst)
        $onehot0(pattern.highSel) && $onehot0(pattern.lowSel) &&
        ((pattern.highSel & pattern.lowSel) == 3'b000))
        else begin
            failCount++;
            $error("Phase pattern is not one-hot or selects one phase twice");
        end

    aErrInAccess: assert property (@(posedge clk) disable iff (!nRst)
        apbRsp.pslverr == (apbReq.psel && apbReq.penable && !mapped))
        else begin
            failCount++;
            $error("pslverr wrong for the current APB phase and address");
        end

endmodule

bind bldcTop bldcChk uChk (
    .clk     (clk),
    .nRst    (nRst),
    .gates   (gates),
    .pattern (pattern),
    .apbReq  (apbReq),
    .apbRsp  (apbRsp)
);

`default_nettype wire

// ==== bldcTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bldc_params.svh"

module bldcTb;

    import bldcPkg::*;

    localparam int MaxPeriod   = 400;   // Longest period programmed below
    localparam int TotalSteps  = 60;
    localparam int SetupCycles = 2000;
    localparam longint WatchdogNs = (longint'(TotalSteps) * (MaxPeriod + 1) + SetupCycles) * 10;

    logic    clk;
    logic    nRst;
    apbReq_t apbReq;
    apbRsp_t apbRsp;
    gates_t  gates;
    status_t status;

    integer seed = 32'hd827_c148;
    int     errors = 0;
    int     checks = 0;

    // Register shadows, updated when a write is accepted
    logic [7:0]  dutyShadow;
    logic [23:0] periodShadow;
    logic        enShadow;
    logic        revShadow;

    status_t     prevStatus;
    logic [7:0]  dutyPrev;
    logic [23:0] periodPrev;
    logic        revPrev;
    logic [7:0]  stepDuty;    // Duty the PWM holds in this step
    int          stepPeriod;
    int          cycle;
    int          lastChange;
    int          sinceChange;
    int          stepChanges;
    int          pulseLen;
    logic        pulseClean;

    tbClkGen uClk (.clk(clk));

    bldcTop dut (
        .clk    (clk),
        .nRst   (nRst),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .gates  (gates),
        .status (status)
    );

    // {highSel, lowSel}, bit 0 = phase a
    function automatic logic [5:0] stepPattern(input logic [2:0] step);
        case (step)
            3'd0: return {3'b001, 3'b010};
            3'd1: return {3'b001, 3'b100};
            3'd2: return {3'b010, 3'b100};
            3'd3: return {3'b010, 3'b001};
            3'd4: return {3'b100, 3'b001};
            3'd5: return {3'b100, 3'b010};
            default: return 6'd0;
        endcase
    endfunction

    // One step back is five steps on modulo 6
    function automatic logic [2:0] stepAfter(input logic [2:0] step, input logic rev);
        int next;
        next = (int'(step) + (rev ? 5 : 1)) % 6;
        return next[2:0];
    endfunction

    // Gate on-time per PWM period, -1 for always on
    function automatic int onTime(input logic [7:0] d);
        if (d == 8'hFF) return -1;
        if (d <= `BLDC_DEAD_CYCLES) return 0;
        return int'(d) - `BLDC_DEAD_CYCLES;
    endfunction

    function automatic logic [31:0] expectedRead(input logic [7:0] addr);
        case (addr)
            `BLDC_ADDR_CTRL:   return {30'd0, revShadow, enShadow};
            `BLDC_ADDR_DUTY:   return {24'd0, dutyShadow};
            `BLDC_ADDR_PERIOD: return {8'd0, periodShadow};
            default:           return 32'd0;   // STATUS is only read while idle
        endcase
    endfunction

    function automatic int phaseIdx(input logic [2:0] oneHot);
        return oneHot[0] ? 0 : (oneHot[1] ? 1 : 2);
    endfunction

    function automatic logic gateBit(input gates_t g, input int idx);
        logic [5:0] gv;
        gv = g;
        return gv[idx];
    endfunction

    task automatic reportFail(input string msg);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic expErr);
        @(negedge clk);
        apbReq = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
        @(negedge clk);
        apbReq.penable = 1'b1;
        if (!expErr) begin
            case (addr)
                `BLDC_ADDR_CTRL: begin
                    enShadow  <= data[0];
                    revShadow <= data[1];
                end
                `BLDC_ADDR_DUTY:   dutyShadow   <= data[7:0];
                `BLDC_ADDR_PERIOD: periodShadow <= data[23:0];
                default: ;
            endcase
        end
        #1;
        checks++;
        if (apbRsp.pslverr !== expErr || apbRsp.pready !== 1'b1) begin
            reportFail($sformatf("write 0x%02h pslverr %b, expected %b", addr,
                       apbRsp.pslverr, expErr));
        end
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic apbRead(input logic [7:0] addr, input logic expErr);
        logic [31:0] expData;
        expData = expectedRead(addr);
        @(negedge clk);
        apbReq = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: 32'd0};
        @(negedge clk);
        apbReq.penable = 1'b1;
        #1;
        checks++;
        if (apbRsp.pslverr !== expErr) begin
            reportFail($sformatf("read 0x%02h pslverr %b, expected %b", addr,
                       apbRsp.pslverr, expErr));
        end
        else if (!expErr && apbRsp.prdata !== expData) begin
            reportFail($sformatf("read 0x%02h gave 0x%08h, expected 0x%08h", addr,
                       apbRsp.prdata, expData));
        end
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic waitSteps(input int n);
        int target;
        target = stepChanges + n;
        while (stepChanges < target) @(negedge clk);
    endtask

    task automatic disableAndWait();
        int waited;
        waited = 0;
        apbWrite(`BLDC_ADDR_CTRL, 32'd0, 1'b0);
        while (status.state != IDLE) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (waited > 2) reportFail($sformatf("IDLE reached %0d cycles after disable", waited));
    endtask

    // Compares state, step timing and gates on every falling edge
    always @(negedge clk) begin : monitor
        logic [5:0] pat;
        int         hiP;
        int         loP;
        int         flP;
        logic       hg;
        if (!nRst) begin
            prevStatus  = '0;
            cycle       = 0;
            lastChange  = 0;
            sinceChange = 0;
            stepChanges = 0;
            pulseLen    = 0;
            pulseClean  = 1'b0;
            dutyPrev    = `BLDC_RST_DUTY;
            periodPrev  = `BLDC_RST_PERIOD;
            revPrev     = 1'b0;
            stepDuty    = `BLDC_RST_DUTY;
        end
        else begin
            cycle++;
            if (status != prevStatus) begin
                checks++;
                if (status.state == ALIGN) begin
                    if (prevStatus.state != IDLE || status.step != 3'd0)
                        reportFail("ALIGN entered wrongly");
                end
                else if (status.state == RUN) begin
                    if (status.step != stepAfter(prevStatus.step, revPrev))
                        reportFail($sformatf("step %0d after %0d", status.step, prevStatus.step));
                    if (prevStatus.state == RUN && cycle - lastChange != stepPeriod + 1)
                        reportFail($sformatf("step lasted %0d cycles, expected %0d",
                                   cycle - lastChange, stepPeriod + 1));
                    stepChanges++;
                end
                else if (status.step != 3'd0) begin
                    reportFail("IDLE with nonzero step");
                end
                stepPeriod  = int'(periodPrev);
                lastChange  = cycle;
                sinceChange = 0;
                stepDuty    = dutyPrev;
                pulseClean  = 1'b0;
            end
            sinceChange++;
            checks++;
            if ((gates.aHi & gates.aLo) | (gates.bHi & gates.bLo) | (gates.cHi & gates.cLo))
                reportFail("both gates of a leg high");
            if (status.state == IDLE) begin
                pulseLen = 0;
                if (sinceChange >= 2 && gates != '0) reportFail("gates on while IDLE");
            end
            else begin
                pat = stepPattern(status.step);
                hiP = phaseIdx(pat[5:3]);
                loP = phaseIdx(pat[2:0]);
                flP = 3 - hiP - loP;
                if (sinceChange >= 2 && (gateBit(gates, 5 - 2*flP) || gateBit(gates, 4 - 2*flP)))
                    reportFail("floating phase driven");
                if (sinceChange >= 6 && !gateBit(gates, 4 - 2*loP))
                    reportFail("low switch of lowSel phase off");
                hg = gateBit(gates, 5 - 2*hiP);
                if (sinceChange >= 8) begin
                    if (onTime(stepDuty) < 0 && !hg) reportFail("high gate off at duty 255");
                    if (onTime(stepDuty) == 0 && hg) reportFail("high gate on at low duty");
                end
                if (hg) begin
                    if (pulseLen == 0) pulseClean = 1'b1;
                    pulseLen++;
                end
                else if (pulseLen > 0) begin
                    if (pulseClean && pulseLen != onTime(stepDuty))
                        reportFail($sformatf("high gate on %0d cycles, duty %0d expects %0d",
                                   pulseLen, stepDuty, onTime(stepDuty)));
                    pulseLen = 0;
                end
            end
            prevStatus = status;
            dutyPrev   = dutyShadow;
            periodPrev = periodShadow;
            revPrev    = revShadow;
        end
    end

    initial begin : watchdog
        #(WatchdogNs);
        $display("Timeout: the test did not finish in %0d ns", WatchdogNs);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        int d;
        int p;
        apbReq       = '0;
        nRst         = 1'b0;
        dutyShadow   = `BLDC_RST_DUTY;
        periodShadow = `BLDC_RST_PERIOD;
        enShadow     = 1'b0;
        revShadow    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        nRst = 1'b1;

        apbRead(`BLDC_ADDR_CTRL, 1'b0);
        apbRead(`BLDC_ADDR_DUTY, 1'b0);
        apbRead(`BLDC_ADDR_PERIOD, 1'b0);
        apbRead(`BLDC_ADDR_STATUS, 1'b0);
        apbWrite(`BLDC_ADDR_DUTY, 32'h5A, 1'b0);
        apbWrite(`BLDC_ADDR_PERIOD, 32'd300, 1'b0);
        apbWrite(`BLDC_ADDR_CTRL, 32'd2, 1'b0);
        apbWrite(8'h10, 32'hFFFF_FFFF, 1'b1);
        apbRead(8'h10, 1'b1);
        apbWrite(`BLDC_ADDR_STATUS, 32'h1F, 1'b1);
        apbRead(`BLDC_ADDR_CTRL, 1'b0);
        apbRead(`BLDC_ADDR_DUTY, 1'b0);
        apbRead(`BLDC_ADDR_PERIOD, 1'b0);

        // Forward, then a duty change in the middle of a step
        // Long steps so a second full PWM period fits inside one step
        apbWrite(`BLDC_ADDR_PERIOD, MaxPeriod, 1'b0);
        apbWrite(`BLDC_ADDR_DUTY, 32'd100, 1'b0);
        apbWrite(`BLDC_ADDR_CTRL, 32'd1, 1'b0);
        waitSteps(4);
        apbWrite(`BLDC_ADDR_DUTY, 32'd40, 1'b0);
        waitSteps(4);
        apbWrite(`BLDC_ADDR_CTRL, 32'd3, 1'b0);
        waitSteps(7);
        apbWrite(`BLDC_ADDR_DUTY, 32'd255, 1'b0);
        waitSteps(3);
        apbWrite(`BLDC_ADDR_DUTY, 32'd0, 1'b0);
        waitSteps(3);

        disableAndWait();
        apbRead(`BLDC_ADDR_STATUS, 1'b0);
        apbWrite(`BLDC_ADDR_CTRL, 32'd1, 1'b0);
        waitSteps(2);

        for (int i = 0; i < 8; i++) begin
            d = $random(seed) & 255;
            p = 100 + ($unsigned($random(seed)) % (MaxPeriod - 99));
            apbWrite(`BLDC_ADDR_DUTY, d, 1'b0);
            apbWrite(`BLDC_ADDR_PERIOD, p, 1'b0);
            waitSteps(2);
        end
        disableAndWait();

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.uChk.failCount);
        if (errors == 0 && dut.uChk.failCount == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
bldcPkg.sv
bldcRegs.sv
stepTimer.sv
commutationFsm.sv
pwmGenerator.sv
deadTimeInserter.sv
bldcTop.sv
tbClkGen.sv
bldcChk.sv
bldcTb.sv
